//--- verification/render_input.dat
// 00000001 x_start y_start step : view record, signed 4.23 sign-extended to 32 bits
// 00000002 index colour : sample record, expected RGB332 after the frame; 000000FF ends the data

// View 1, re -2.0 .. 1.75, im 1.5 .. -1.25, step 0.25
00000001 FF000000 00C00000 00200000
// c = 0, interior
00000002 00000068 00
// c = -1, period-2 cycle
00000002 00000064 00
// c = -0.5, main cardioid
00000002 00000066 00
// c = -0.25 + 0.25i
00000002 00000057 00
// c = -0.25 - 0.25i
00000002 00000077 00
// c = -2 + 1.5i, real part on the bound
00000002 00000000 52
// c = 1.75 + 1.5i, |c|^2 above 4
00000002 0000000F 52
// c = -2, real part on the bound
00000002 00000060 52
// c = 0.5, escapes at step 5
00000002 0000006A 52
// c = 1, escapes at step 2
00000002 0000006C 52
// c = -2 - 1.25i
00000002 000000B0 52
// c = 1.75 - 1.25i
00000002 000000BF 52

// View 2, re -1.0 .. 0.875, im 0.75 .. -0.625, step 0.125
00000001 FF800000 00600000 00100000
// c = -1
00000002 00000060 00
// c = -0.5
00000002 00000064 00
// c = -0.25 + 0.25i
00000002 00000046 00
// c = 0
00000002 00000068 00
// c = 0.125
00000002 00000069 00
// c = 0.5 + 0.75i, escapes at step 3
00000002 0000000C 52
// c = 0.875 + 0.75i, escapes at step 2
00000002 0000000F 52
// c = 0.875, escapes at step 3
00000002 0000006F 52
// c = 0.875 - 0.625i, escapes at step 2
00000002 000000BF 52

000000FF

//--- flist.f
+incdir+hdl
hdl/mandel_pkg.sv
hdl/pixel_scan.sv
hdl/escape_iterator.sv
hdl/pixel_writer.sv
hdl/mandel_render_top.sv
verification/tb_mandel_render.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Mandelbrot renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_mandel
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/1ps \
	--top-module tb_mandel_render \
	-f flist.f \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Verdict comes from the log
if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "Testbench reported failure"
	exit 1
fi

echo "Testbench reported no failure"
exit 0

//--- verification/tb_mandel_render.sv
`default_nettype none

`include "mandel_cfg.svh"

module tb_mandel_render;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_PIXELS  = `FRAME_W * `FRAME_H;
	localparam int STIM_DEPTH    = 128;
	// First write may wait for one point at the iteration limit
	localparam int START_TIMEOUT = 2 * `ITER_MAX + 16;
	// Whole frame at the iteration limit plus ack delays
	localparam int FRAME_TIMEOUT = FRAME_PIXELS * (`ITER_MAX + 8);

	// Record tags of the data file
	localparam logic [31:0] VIEW_TAG   = 32'h0000_0001;
	localparam logic [31:0] SAMPLE_TAG = 32'h0000_0002;
	localparam logic [31:0] END_TAG    = 32'h0000_00FF;

	logic                  clk;
	logic                  reset;
	logic                  start;
	mandel_pkg::view_t     view;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [`PIX_IDX_W-1:0] wb_adr;
	mandel_pkg::rgb332_t   wb_dat;
	logic                  wb_ack;
	logic                  done;

	// Frame buffer seen through the Wishbone slave
	mandel_pkg::rgb332_t   frame_buf [0:FRAME_PIXELS-1];
	logic                  written [0:FRAME_PIXELS-1];
	logic [`PIX_IDX_W-1:0] next_adr;
	int                    write_count;

	logic [31:0] stim [0:STIM_DEPTH-1];
	integer      seed = 32'h8991_ba9d;
	int          mismatch_count = 0;
	int          failure_count = 0;
	logic        aborted = 1'b0;

	mandel_render_top dut_i (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.view   (view),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we  (wb_we),
		.wb_adr (wb_adr),
		.wb_dat (wb_dat),
		.wb_ack (wb_ack),
		.done   (done)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Compare and report
	//////////////////////////////////////////////////

	task automatic check_colour(input string name, input mandel_pkg::rgb332_t expected,
		input mandel_pkg::rgb332_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
			mismatch_count++;
		end
	endtask

	task automatic check_index(input string name, input logic [`PIX_IDX_W-1:0] expected,
		input logic [`PIX_IDX_W-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
			mismatch_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
			mismatch_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("ERROR: %s at %0t", what, $time);
		failure_count++;
	endtask

	//////////////////////////////////////////////////
	// Frame buffer bookkeeping
	//////////////////////////////////////////////////

	// Poison pattern so a missing write shows up
	task automatic clear_frame_buffer();
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			frame_buf[i] = i[7:0] ^ 8'h5A;
			written[i]   = 1'b0;
		end
		next_adr    = '0;
		write_count = 0;
	endtask

	// Each index written once and in order
	task automatic record_write(input logic [`PIX_IDX_W-1:0] adr,
		input mandel_pkg::rgb332_t dat);
		check_index("wb_adr", next_adr, adr);
		if (int'(adr) >= FRAME_PIXELS) begin
			report_failure($sformatf("write to address 0x%h lies outside the frame", adr));
		end else begin
			if (written[adr]) begin
				report_failure($sformatf("address 0x%h written twice in one frame", adr));
			end
			written[adr]   = 1'b1;
			frame_buf[adr] = dat;
		end
		next_adr    = next_adr + 1'b1;
		write_count = write_count + 1;
	endtask

	// Wishbone slave acking after 0 to 3 extra cycles
	initial begin : wishbone_slave
		logic [`PIX_IDX_W-1:0] req_adr;
		mandel_pkg::rgb332_t   req_dat;
		logic                  req_pending;
		int                    ack_wait;
		wb_ack      = 1'b0;
		req_pending = 1'b0;
		ack_wait    = 0;
		forever begin
			@(negedge clk);
			if (wb_ack) begin
				wb_ack = 1'b0;
				// Master must drop the strobe after an ack
				check_flag("wb_stb", 1'b0, wb_stb);
			end else if (wb_stb) begin
				if (!req_pending) begin
					req_pending = 1'b1;
					req_adr     = wb_adr;
					req_dat     = wb_dat;
					ack_wait    = $random(seed) & 3;
				end else begin
					// Request held steady while stalled
					check_index("wb_adr", req_adr, wb_adr);
					check_colour("wb_dat", req_dat, wb_dat);
				end
				check_flag("wb_we", 1'b1, wb_we);
				check_flag("wb_cyc", 1'b1, wb_cyc);
				if (ack_wait == 0) begin
					wb_ack      = 1'b1;
					req_pending = 1'b0;
					record_write(wb_adr, wb_dat);
				end else begin
					ack_wait = ack_wait - 1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Frame sequencing
	//////////////////////////////////////////////////

	// Bus and done quiet with no start
	task automatic watch_idle_bus(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_flag("wb_cyc", 1'b0, wb_cyc);
			check_flag("wb_stb", 1'b0, wb_stb);
			check_flag("done", 1'b0, done);
		end
	endtask

	task automatic wait_write_start(output logic ok);
		int cycles;
		cycles = 0;
		while (!wb_stb && cycles < START_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		ok = wb_stb;
		if (!ok) begin
			report_failure("timeout waiting for the first write of the frame");
		end
	endtask

	task automatic wait_done(output logic ok);
		int cycles;
		cycles = 0;
		while (!done && cycles < FRAME_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		ok = done;
		if (!ok) begin
			report_failure("timeout waiting for done at the end of the frame");
		end
	endtask

	// One start pulse followed by the whole frame
	task automatic run_frame(input mandel_pkg::view_t v, input int frame_no, output logic ok);
		clear_frame_buffer();
		@(negedge clk);
		view  = v;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// Done of an earlier frame lasts until the new first write
		check_flag("done", frame_no > 0, done);
		wait_write_start(ok);
		if (ok) begin
			check_flag("done", 1'b0, done);
			wait_done(ok);
		end
		if (ok && write_count != FRAME_PIXELS) begin
			report_failure($sformatf("frame %0d ended after %0d writes instead of %0d",
				frame_no, write_count, FRAME_PIXELS));
		end
	endtask

	task automatic compare_sample(input logic [31:0] idx_word, input logic [31:0] colour_word);
		if (idx_word >= FRAME_PIXELS) begin
			report_failure($sformatf("sample index %0d lies outside the frame", idx_word));
		end else begin
			check_colour($sformatf("frame_buf[%0d]", idx_word), colour_word[7:0],
				frame_buf[idx_word]);
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int                ptr;
		int                frame_no;
		logic              ok;
		logic [31:0]       tag;
		mandel_pkg::view_t next_view;
		reset = 1'b1;
		start = 1'b0;
		view  = '0;
		$readmemh("verification/render_input.dat", stim);
		repeat (2) @(negedge clk);
		reset = 1'b0;
		watch_idle_bus(10);

		ptr      = 0;
		frame_no = 0;
		while (!aborted && ptr < STIM_DEPTH - 3 && stim[ptr] != END_TAG) begin
			tag = stim[ptr];
			if (tag == VIEW_TAG) begin
				next_view.x_start = stim[ptr + 1][`FIX_W-1:0];
				next_view.y_start = stim[ptr + 2][`FIX_W-1:0];
				next_view.step    = stim[ptr + 3][`FIX_W-1:0];
				run_frame(next_view, frame_no, ok);
				aborted  = !ok;
				frame_no = frame_no + 1;
				ptr      = ptr + 4;
			end else if (tag == SAMPLE_TAG && frame_no > 0) begin
				compare_sample(stim[ptr + 1], stim[ptr + 2]);
				ptr = ptr + 3;
			end else begin
				report_failure($sformatf("bad record tag 0x%h at word %0d of the data file",
					tag, ptr));
				aborted = 1'b1;
			end
		end
		if (frame_no == 0) begin
			report_failure("data file holds no view");
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/mandel_render_top.sv
`default_nettype none

`include "mandel_cfg.svh"

module mandel_render_top (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 start,
	input  wire mandel_pkg::view_t    view,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output logic [`PIX_IDX_W-1:0]     wb_adr,
	output mandel_pkg::rgb332_t       wb_dat,
	input  wire logic                 wb_ack,
	output logic                      done
);

	// Scan to iterator
	mandel_pkg::pixel_job_t job;
	logic                   job_valid;
	logic                   job_ready;

	// Iterator to writer
	mandel_pkg::pixel_result_t result;
	logic                      res_valid;
	logic                      res_ready;

	//////////////////////////////////////////////////
	// Pipeline
	//////////////////////////////////////////////////

	// One job per pixel, row-major
	pixel_scan scan_i (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.view      (view),
		.job       (job),
		.job_valid (job_valid),
		.job_ready (job_ready)
	);

	// Variable latency per point
	escape_iterator iter_i (
		.clk       (clk),
		.reset     (reset),
		.job       (job),
		.job_valid (job_valid),
		.job_ready (job_ready),
		.result    (result),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

	// Colour and frame buffer write
	pixel_writer writer_i (
		.clk       (clk),
		.reset     (reset),
		.result    (result),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat    (wb_dat),
		.wb_ack    (wb_ack),
		.done      (done)
	);

endmodule

`default_nettype wire

//--- hdl/pixel_writer.sv
`default_nettype none

`include "mandel_cfg.svh"

module pixel_writer (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire mandel_pkg::pixel_result_t   result,
	input  wire logic                        res_valid,
	output logic                             res_ready,
	output logic                             wb_cyc,
	output logic                             wb_stb,
	output logic                             wb_we,
	output logic [`PIX_IDX_W-1:0]            wb_adr,
	output mandel_pkg::rgb332_t              wb_dat,
	input  wire logic                        wb_ack,
	output logic                             done
);

	mandel_pkg::write_state_e state;

	//////////////////////////////////////////////////
	// Palette
	//////////////////////////////////////////////////

	// Bins by powers of two below ITER_MAX with half and quarter sharing a colour
	function automatic mandel_pkg::rgb332_t colour_of(input logic [`ITER_W-1:0] n);
		if (n >= `ITER_MAX) begin
			// Interior
			return 8'h00;
		end else if (n >= (`ITER_MAX >> 2)) begin
			return 8'h64;
		end else if (n >= (`ITER_MAX >> 3)) begin
			return 8'hA9;
		end else if (n >= (`ITER_MAX >> 4)) begin
			return 8'h65;
		end else if (n >= (`ITER_MAX >> 5)) begin
			return 8'h25;
		end else if (n >= (`ITER_MAX >> 6)) begin
			return 8'h6A;
		end else begin
			// Fast escape
			return 8'h52;
		end
	endfunction

	//////////////////////////////////////////////////
	// Wishbone write FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mandel_pkg::WR_IDLE;
			done  <= 1'b0;
		end else begin
			case (state)
				mandel_pkg::WR_IDLE: begin
					if (res_valid) begin
						state <= mandel_pkg::WR_WRITE;
						// First pixel of a new frame
						if (result.idx == '0) begin
							done <= 1'b0;
						end
					end
				end
				mandel_pkg::WR_WRITE: begin
					if (wb_ack) begin
						// Cycle drops for at least one clock
						state <= mandel_pkg::WR_IDLE;
						if (wb_adr == `PIX_IDX_W'(`FRAME_W * `FRAME_H - 1)) begin
							done <= 1'b1;
						end
					end
				end
				default: begin
					state <= mandel_pkg::WR_IDLE;
				end
			endcase
		end
	end

	// Address and colour latched on accept and held through the cycle
	always_ff @(posedge clk) begin
		if (state == mandel_pkg::WR_IDLE && res_valid) begin
			wb_adr <= result.idx;
			wb_dat <= colour_of(result.count);
		end
	end

	assign res_ready = (state == mandel_pkg::WR_IDLE);

	// Write-only master
	assign wb_stb = (state == mandel_pkg::WR_WRITE);
	assign wb_cyc = wb_stb;
	assign wb_we  = wb_stb;

	// Slave sees a steady request while it stalls
	assert property (@(posedge clk) disable iff (reset)
		(wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat)));

endmodule

`default_nettype wire

//--- hdl/escape_iterator.sv
`default_nettype none

`include "mandel_cfg.svh"

module escape_iterator (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire mandel_pkg::pixel_job_t    job,
	input  wire logic                      job_valid,
	output logic                           job_ready,
	output mandel_pkg::pixel_result_t      result,
	output logic                           res_valid,
	input  wire logic                      res_ready
);

	mandel_pkg::iter_state_e state;

	// Point being iterated
	logic [`PIX_IDX_W-1:0] idx_q;
	mandel_pkg::fix_t      c_re;
	mandel_pkg::fix_t      c_im;

	// Current z and its squares
	mandel_pkg::fix_t z_re;
	mandel_pkg::fix_t z_im;
	mandel_pkg::fix_t sq_re;
	mandel_pkg::fix_t sq_im;

	logic [`ITER_W-1:0] count;
	logic [`ITER_W-1:0] count_next;

	// Next step
	mandel_pkg::fix_t re_im;
	mandel_pkg::fix_t z_re_next;
	mandel_pkg::fix_t z_im_next;
	mandel_pkg::fix_t sq_re_next;
	mandel_pkg::fix_t sq_im_next;
	mandel_pkg::fix_t mag_next;
	logic             escape;

	//////////////////////////////////////////////////
	// z(n+1) = z(n)^2 + c
	//////////////////////////////////////////////////

	// Squares come from registers so only the cross term is new
	assign re_im     = mandel_pkg::fix_mult(z_re, z_im);
	assign z_re_next = sq_re - sq_im + c_re;
	assign z_im_next = (re_im <<< 1) + c_im;

	// Squares of the new z for reuse next step
	assign sq_re_next = mandel_pkg::fix_mult(z_re_next, z_re_next);
	assign sq_im_next = mandel_pkg::fix_mult(z_im_next, z_im_next);
	assign mag_next   = sq_re_next + sq_im_next;

	assign count_next = count + 1'b1;

	// Magnitude may wrap once a component is out of range
	// but the component test catches that step
	assign escape = (mag_next > `ESC_MAG_SQ)
		|| (z_re_next >= `ESC_COMP) || (z_re_next <= -`ESC_COMP)
		|| (z_im_next >= `ESC_COMP) || (z_im_next <= -`ESC_COMP)
		|| (count_next == `ITER_MAX);

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mandel_pkg::ITER_IDLE;
		end else begin
			case (state)
				mandel_pkg::ITER_IDLE: begin
					if (job_valid) begin
						state <= mandel_pkg::ITER_CALC;
					end
				end
				mandel_pkg::ITER_CALC: begin
					if (escape) begin
						state <= mandel_pkg::ITER_DONE;
					end
				end
				mandel_pkg::ITER_DONE: begin
					// Hold result until writer takes it
					if (res_ready) begin
						state <= mandel_pkg::ITER_IDLE;
					end
				end
				default: begin
					state <= mandel_pkg::ITER_IDLE;
				end
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (state == mandel_pkg::ITER_IDLE && job_valid) begin
			idx_q <= job.idx;
			c_re  <= job.c_re;
			c_im  <= job.c_im;
			z_re  <= '0;
			z_im  <= '0;
			sq_re <= '0;
			sq_im <= '0;
			count <= '0;
		end else if (state == mandel_pkg::ITER_CALC) begin
			z_re  <= z_re_next;
			z_im  <= z_im_next;
			sq_re <= sq_re_next;
			sq_im <= sq_im_next;
			count <= count_next;
		end
	end

	assign job_ready = (state == mandel_pkg::ITER_IDLE);
	assign res_valid = (state == mandel_pkg::ITER_DONE);

	always_comb begin
		result.idx   = idx_q;
		result.count = count;
	end

	// Limit check ends CALC before the count can pass ITER_MAX
	assert property (@(posedge clk) disable iff (reset)
		(state != mandel_pkg::ITER_IDLE) |-> (count <= `ITER_MAX));

endmodule

`default_nettype wire

//--- hdl/pixel_scan.sv
`default_nettype none

`include "mandel_cfg.svh"

module pixel_scan (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   start,
	input  wire mandel_pkg::view_t      view,
	output mandel_pkg::pixel_job_t      job,
	output logic                        job_valid,
	input  wire logic                   job_ready
);

	localparam int COL_W = $clog2(`FRAME_W);
	localparam int ROW_W = $clog2(`FRAME_H);

	// Frame in progress
	logic active;

	// Position in the frame
	logic [COL_W-1:0]      col;
	logic [ROW_W-1:0]      row;
	logic [`PIX_IDX_W-1:0] idx;

	// Coordinate of the current pixel
	mandel_pkg::fix_t cur_re;
	mandel_pkg::fix_t cur_im;

	// View values needed after capture
	mandel_pkg::fix_t x_start_q;
	mandel_pkg::fix_t step_q;

	logic fire;
	logic row_end;
	logic last_pix;

	assign fire     = job_valid && job_ready;
	assign row_end  = (col == COL_W'(`FRAME_W - 1));
	assign last_pix = row_end && (row == ROW_W'(`FRAME_H - 1));

	//////////////////////////////////////////////////
	// Frame control and counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			col    <= '0;
			row    <= '0;
			idx    <= '0;
		end else if (start && !active) begin
			// New frame only from idle
			active <= 1'b1;
			col    <= '0;
			row    <= '0;
			idx    <= '0;
		end else if (fire) begin
			idx <= idx + 1'b1;
			if (last_pix) begin
				active <= 1'b0;
			end
			if (row_end) begin
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Coordinate stepping
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start && !active) begin
			x_start_q <= view.x_start;
			step_q    <= view.step;
			cur_re    <= view.x_start;
			cur_im    <= view.y_start;
		end else if (fire) begin
			if (row_end) begin
				// Back to left edge and one row down
				cur_re <= x_start_q;
				cur_im <= cur_im - step_q;
			end else begin
				cur_re <= cur_re + step_q;
			end
		end
	end

	// Job stays put until taken
	assign job_valid = active;

	always_comb begin
		job.idx  = idx;
		job.c_re = cur_re;
		job.c_im = cur_im;
	end

	// Index stays inside the frame
	assert property (@(posedge clk) disable iff (reset)
		job_valid |-> (job.idx <= (`FRAME_W * `FRAME_H - 1)));

endmodule

`default_nettype wire

//--- hdl/mandel_pkg.sv
`default_nettype none

`include "mandel_cfg.svh"

package mandel_pkg;

	//////////////////////////////////////////////////
	// Data types
	//////////////////////////////////////////////////

	// Signed 4.23 value
	typedef logic signed [`FIX_W-1:0] fix_t;

	// View of one frame by top-left corner and pixel pitch
	typedef struct packed {
		fix_t x_start;
		fix_t y_start;
		fix_t step;
	} view_t;

	// One point to iterate
	typedef struct packed {
		logic [`PIX_IDX_W-1:0] idx;
		fix_t                  c_re;
		fix_t                  c_im;
	} pixel_job_t;

	// Iteration count for one point
	typedef struct packed {
		logic [`PIX_IDX_W-1:0] idx;
		logic [`ITER_W-1:0]    count;
	} pixel_result_t;

	// R[7:5] G[4:2] B[1:0]
	typedef logic [7:0] rgb332_t;

	// Iterator FSM
	typedef enum logic [1:0] {ITER_IDLE, ITER_CALC, ITER_DONE} iter_state_e;

	// Writer FSM
	typedef enum logic {WR_IDLE, WR_WRITE} write_state_e;

	//////////////////////////////////////////////////
	// 4.23 multiply
	//////////////////////////////////////////////////

	// Sign bit plus the 26 bits around the binary point of the full product
	function automatic fix_t fix_mult(input fix_t a, input fix_t b);
		logic signed [2*`FIX_W-1:0] full;
		full = a * b;
		return {full[2*`FIX_W-1], full[`FIX_W+`FIX_FRAC-2:`FIX_FRAC]};
	endfunction

endpackage

`default_nettype wire

//--- hdl/mandel_cfg.svh
`ifndef MANDEL_CFG_SVH
`define MANDEL_CFG_SVH

//////////////////////////////////////////////////
// Frame geometry
//////////////////////////////////////////////////

// Frame size in pixels
`define FRAME_W 16
`define FRAME_H 12

// Wide enough for FRAME_W * FRAME_H - 1
`define PIX_IDX_W ($clog2(`FRAME_W * `FRAME_H))

//////////////////////////////////////////////////
// Fixed point and iteration
//////////////////////////////////////////////////

// Signed 4.23
`define FIX_W    27
`define FIX_FRAC 23

// Escape-time limit and a count wide enough to hold it
`define ITER_MAX 1000
`define ITER_W   ($clog2(`ITER_MAX + 1))

// 4.0 bound on |z|^2
`define ESC_MAG_SQ (4 << `FIX_FRAC)
// 2.0 bound on each component of z
`define ESC_COMP   (2 << `FIX_FRAC)

`endif
